// ==== vlog.f ====
hdl/audio_pkg.sv
hdl/sample_push_if.sv
hdl/wishbone_bus_logic.sv
hdl/sample_fifo.sv
hdl/i2s_transmitter.sv
hdl/audio_peripheral_top.sv
testbench/audio_peripheral_assertions.sv
testbench/tb_audio_peripheral.sv

// ==== Makefile ====
VERILATOR  ?= verilator
VFLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall
TOP        := tb_audio_peripheral
FILELIST   := vlog.f
BUILD_DIR  := obj_dir
PASS_MSG   := TEST RESULT: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# pass only if the simulation printed the pass line
run: build
	@out=$$(./$(BUILD_DIR)/V$(TOP) 2>&1); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR)

// ==== testbench/tb_audio_peripheral.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_audio_peripheral;

   localparam int FIFO_DEPTH  = 4;
   localparam int BCLK_DIV    = 2;
   localparam int INIT_CYCLES = 64;
   localparam int CLK_NS      = 20;
   localparam int SW          = audio_pkg::SAMPLE_W;
   // one i2s frame is 64 bit clocks
   localparam int FRAME_CLKS  = 64 * 2 * BCLK_DIV;
   localparam int FRAME_NS    = FRAME_CLKS * CLK_NS;
   // two clocks per status read gives two frames of polling
   localparam int POLL_LIMIT  = FRAME_CLKS;
   localparam logic [7:0] DIP_VALUE = 8'hA5;
   localparam logic [4:0] BTN_VALUE = 5'h13;

   typedef enum {OP_WRITE, OP_READ, OP_POLL, OP_WAIT} op_kind_t;

   typedef struct {
      op_kind_t    kind;
      logic [31:0] addr;
      logic [31:0] data;
      logic [3:0]  sel;
      logic [31:0] exp_val;
   } bus_op_t;

   logic        clk = 1'b0;
   logic        reset;
   logic        wb_stb;
   logic        wb_we;
   logic [31:0] wb_addr;
   logic [31:0] wb_data;
   logic [3:0]  wb_sel;
   logic        wb_ack;
   logic [31:0] wb_rdata;
   logic [7:0]  dip;
   logic [4:0]  buttons;
   logic [7:0]  led;
   logic        i2s_bclk;
   logic        i2s_lrclk;
   logic        i2s_sdata;

   bus_op_t                   ops[$];
   audio_pkg::stereo_sample_t exp_q[$];
   logic [31:0]               lfsr_state = 32'hb480_0bce;
   logic [SW-1:0]             model_left = '0;
   logic [SW-1:0]             model_right = '0;
   // right sample of the last word put in the table
   logic [SW-1:0]             last_right = '0;
   int                        error_count = 0;
   bit                        table_ready = 1'b0;

   // i2s receiver state
   int                        rx_slot = 0;
   bit                        rx_synced = 1'b0;
   logic                      rx_lr_prev = 1'b0;
   logic [SW-1:0]             rx_left = '0;
   logic [SW-1:0]             rx_right = '0;

   always #(CLK_NS / 2) clk = ~clk;

   audio_peripheral_top #(
      .FIFO_DEPTH  (FIFO_DEPTH),
      .BCLK_DIV    (BCLK_DIV),
      .INIT_CYCLES (INIT_CYCLES)
   ) i_dut (
      .clk         (clk),
      .reset       (reset),
      .i_wb_stb    (wb_stb),
      .i_wb_we     (wb_we),
      .i_wb_addr   (wb_addr),
      .i_wb_data   (wb_data),
      .i_wb_sel    (wb_sel),
      .o_wb_ack    (wb_ack),
      .o_wb_data   (wb_rdata),
      .i_dip       (dip),
      .i_buttons   (buttons),
      .o_led       (led),
      .o_i2s_bclk  (i2s_bclk),
      .o_i2s_lrclk (i2s_lrclk),
      .o_i2s_sdata (i2s_sdata)
   );

   ////////////////////////////////////////
   // failure reporting and compare
   ////////////////////////////////////////

   task automatic stop_on_error(input string why);
      $display("%s", why);
      $display("TEST RESULT: FAIL");
      $fatal(1, "simulation stopped on first error");
   endtask

   task automatic check(input string what, input logic [63:0] got, input logic [63:0] exp);
      if (got !== exp) begin
         error_count++;
         stop_on_error($sformatf("[FAIL] %0t ns: %s: got %h, expected %h",
                                 $time, what, got, exp));
      end
   endtask

   ////////////////////////////////////////
   // stimulus helpers
   ////////////////////////////////////////

   // fibonacci lfsr with taps 32 22 2 1
   function automatic logic [31:0] lfsr_step(input logic [31:0] s);
      return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
   endfunction

   // one step per bit and a zero sample becomes one
   function automatic logic [SW-1:0] next_sample();
      logic [SW-1:0] val;
      val = '0;
      for (int k = 0; k < SW; k++) begin
         lfsr_state = lfsr_step(lfsr_state);
         val = {val[SW-2:0], lfsr_state[0]};
      end
      if (val == '0)
         val = SW'(1);
      return val;
   endfunction

   function automatic logic [31:0] status_word(input bit full, input bit init, input bit pend);
      logic [31:0] w;
      w = '0;
      w[audio_pkg::STAT_FULL_BIT] = full;
      w[audio_pkg::STAT_INIT_BIT] = init;
      w[audio_pkg::STAT_PEND_BIT] = pend;
      return w;
   endfunction

   function automatic void add_op(input op_kind_t kind, input logic [31:0] addr,
                                  input logic [31:0] data, input logic [3:0] sel,
                                  input logic [31:0] exp_val);
      bus_op_t op;
      op.kind    = kind;
      op.addr    = addr;
      op.data    = data;
      op.sel     = sel;
      op.exp_val = exp_val;
      ops.push_back(op);
   endfunction

   // left then right with a junk top byte the bus must drop
   function automatic void add_word(input bit poll_first);
      logic [SW-1:0] l;
      logic [SW-1:0] r;
      l = next_sample();
      r = next_sample();
      last_right = r;
      if (poll_first)
         add_op(OP_POLL, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, 32'h0);
      add_op(OP_WRITE, audio_pkg::ADDR_LEFT, {8'hEE, l}, 4'b0111, 32'h0);
      add_op(OP_WRITE, audio_pkg::ADDR_RIGHT, {8'hEE, r}, 4'b0111, 32'h0);
   endfunction

   // sample registers take byte lanes 0..2 and a right write queues the word
   function automatic void track_sample_write(input bus_op_t op);
      audio_pkg::stereo_sample_t word;
      for (int b = 0; b < SW / 8; b++) begin
         if (op.sel[b] && op.addr == audio_pkg::ADDR_LEFT)
            model_left[8*b +: 8] = op.data[8*b +: 8];
         if (op.sel[b] && op.addr == audio_pkg::ADDR_RIGHT)
            model_right[8*b +: 8] = op.data[8*b +: 8];
      end
      if (op.addr == audio_pkg::ADDR_RIGHT && (|op.sel)) begin
         word.left  = model_left;
         word.right = model_right;
         exp_q.push_back(word);
      end
   endfunction

   // single bus cycle with the ack exactly one clock later
   task automatic bus_cycle(input logic we, input logic [31:0] addr, input logic [31:0] data,
                            input logic [3:0] sel, output logic [31:0] rdata);
      int waited;
      @(posedge clk);
      wb_stb  <= 1'b1;
      wb_we   <= we;
      wb_addr <= addr;
      wb_data <= data;
      wb_sel  <= sel;
      @(posedge clk);
      wb_stb  <= 1'b0;
      wb_we   <= 1'b0;
      waited = 0;
      do begin
         @(negedge clk);
         waited++;
      end while (!wb_ack && waited < 4);
      if (!wb_ack) begin
         stop_on_error("the bus gave no ack within four clocks of a strobe");
      end else begin
         check("ack latency in clocks", 64'(waited), 64'd1);
         rdata = wb_rdata;
      end
   endtask

   ////////////////////////////////////////
   // i2s receiver model
   ////////////////////////////////////////

   // lrclk falling marks slot 0 and data is valid on rising bclk
   always @(posedge i2s_bclk) begin
      if (rx_lr_prev && !i2s_lrclk) begin
         rx_slot   = 0;
         rx_synced = 1'b1;
      end else begin
         rx_slot = rx_slot + 1;
      end
      rx_lr_prev = i2s_lrclk;
      if (rx_synced) begin
         // msb one slot after each ws edge
         if (rx_slot >= 1 && rx_slot <= SW)
            rx_left = {rx_left[SW-2:0], i2s_sdata};
         if (rx_slot >= 33 && rx_slot <= 32 + SW)
            rx_right = {rx_right[SW-2:0], i2s_sdata};
         if (rx_slot == 63 && {rx_left, rx_right} != '0) begin
            if (exp_q.size() == 0) begin
               stop_on_error("the I2S receiver saw a nonzero frame that was never written");
            end else begin
               check("i2s stereo word", 64'({rx_left, rx_right}), 64'(exp_q[0]));
               void'(exp_q.pop_front());
            end
         end
      end
   end

   ////////////////////////////////////////
   // watchdog
   ////////////////////////////////////////

   initial begin
      longint limit_ns;
      wait (table_ready);
      // table length times frame time times three
      limit_ns = longint'(ops.size()) * FRAME_NS * 3;
      #(limit_ns);
      stop_on_error($sformatf("timeout: the run did not finish within %0d ns", limit_ns));
   end

   ////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////

   initial begin
      logic [31:0] rdata;
      int          polls;

      wb_stb  <= 1'b0;
      wb_we   <= 1'b0;
      wb_addr <= 32'h0;
      wb_data <= 32'h0;
      wb_sel  <= 4'h0;
      dip     <= DIP_VALUE;
      buttons <= BTN_VALUE;
      reset   <= 1'b1;

      // nothing set right after reset
      add_op(OP_READ, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, status_word(0, 0, 0));
      // led byte lane 0 only
      add_op(OP_WRITE, audio_pkg::ADDR_LED, 32'h1234_565A, 4'b0001, 32'h0);
      add_op(OP_READ, audio_pkg::ADDR_LED, 32'h0, 4'hF, 32'h0000_005A);
      add_op(OP_WRITE, audio_pkg::ADDR_LED, 32'h0000_00FF, 4'b0000, 32'h0);
      add_op(OP_READ, audio_pkg::ADDR_LED, 32'h0, 4'hF, 32'h0000_005A);
      // read-only and unmapped space
      add_op(OP_READ, audio_pkg::ADDR_DIP, 32'h0, 4'hF, {24'h0, DIP_VALUE});
      add_op(OP_READ, audio_pkg::ADDR_BUTTONS, 32'h0, 4'hF, {27'h0, BTN_VALUE});
      add_op(OP_WRITE, audio_pkg::ADDR_DIP, 32'hFFFF_FFFF, 4'hF, 32'h0);
      add_op(OP_WRITE, audio_pkg::ADDR_BUTTONS, 32'hFFFF_FFFF, 4'hF, 32'h0);
      add_op(OP_READ, audio_pkg::ADDR_DIP, 32'h0, 4'hF, {24'h0, DIP_VALUE});
      add_op(OP_READ, audio_pkg::ADDR_BUTTONS, 32'h0, 4'hF, {27'h0, BTN_VALUE});
      add_op(OP_WRITE, 32'h9000_0020, 32'hDEAD_BEEF, 4'hF, 32'h0);
      add_op(OP_READ, 32'h9000_0020, 32'h0, 4'hF, 32'h0);
      add_op(OP_READ, audio_pkg::ADDR_LEFT, 32'h0, 4'hF, 32'h0);
      // one frame is well past the init delay
      add_op(OP_WAIT, 32'h0, 32'd1, 4'h0, 32'h0);
      add_op(OP_READ, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, status_word(0, 1, 0));
      // polled stream followed by an upper-byte-only right write
      for (int w = 0; w < 3; w++)
         add_word(1'b1);
      add_op(OP_POLL, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, 32'h0);
      // every byte differs from the held right sample
      add_op(OP_WRITE, audio_pkg::ADDR_RIGHT, {8'h00, ~last_right}, 4'b0100, 32'h0);
      // drain and line up just after a frame start
      add_op(OP_WAIT, 32'h0, 32'(FIFO_DEPTH + 1), 4'h0, 32'h0);
      // burst without polling overfills by one
      for (int w = 0; w < FIFO_DEPTH + 1; w++)
         add_word(1'b0);
      add_op(OP_READ, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, status_word(1, 1, 1));
      for (int w = 0; w < 3; w++)
         add_word(1'b1);
      add_op(OP_POLL, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, 32'h0);
      add_op(OP_WAIT, 32'h0, 32'(FIFO_DEPTH + 2), 4'h0, 32'h0);
      add_op(OP_READ, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, status_word(0, 1, 0));
      table_ready = 1'b1;

      repeat (3) @(posedge clk);
      reset <= 1'b0;

      for (int i = 0; i < ops.size(); i++) begin
         case (ops[i].kind)
            OP_WRITE: begin
               bus_cycle(1'b1, ops[i].addr, ops[i].data, ops[i].sel, rdata);
               check($sformatf("write data at %h", ops[i].addr), 64'(rdata),
                     64'(ops[i].exp_val));
               track_sample_write(ops[i]);
            end
            OP_READ: begin
               bus_cycle(1'b0, ops[i].addr, 32'h0, ops[i].sel, rdata);
               check($sformatf("read at %h", ops[i].addr), 64'(rdata), 64'(ops[i].exp_val));
               if (ops[i].addr == audio_pkg::ADDR_LED)
                  check("o_led pins", 64'(led), 64'(ops[i].exp_val[7:0]));
            end
            OP_POLL: begin
               polls = 0;
               do begin
                  bus_cycle(1'b0, audio_pkg::ADDR_STATUS, 32'h0, 4'hF, rdata);
                  polls++;
               end while (rdata[audio_pkg::STAT_PEND_BIT] && polls < POLL_LIMIT);
               if (rdata[audio_pkg::STAT_PEND_BIT])
                  stop_on_error("the pending bit never cleared while polling status");
            end
            default: begin
               // wait a number of frame starts
               repeat (ops[i].data) @(negedge i2s_lrclk);
            end
         endcase
      end

      // everything written came out and only silence follows
      check("stereo words never received", 64'(exp_q.size()), 64'd0);
      // the receiver stops on any nonzero frame from here on
      repeat (2) @(negedge i2s_lrclk);

      if (error_count == 0) begin
         $display("TEST RESULT: PASS");
         $finish;
      end else begin
         stop_on_error("errors were recorded during the run");
      end
   end

endmodule

`default_nettype wire

// ==== testbench/audio_peripheral_assertions.sv ====
`timescale 1ns/1ns
`default_nettype none

// bus and fifo protocol rules bound into the bus block and the fifo
module audio_peripheral_assertions (
   input wire logic clk,
   input wire logic reset,
   input wire logic i_push,
   input wire logic i_full,
   input wire logic i_pop,
   input wire logic i_empty,
   input wire logic i_stb,
   input wire logic i_ack
);

   ////////////////////////////////////////
   // fifo side
   ////////////////////////////////////////

   a_no_push_when_full: assert property (
      @(posedge clk) disable iff (reset) !(i_push && i_full)
   ) else $error("push issued while the fifo is full");

   a_no_pop_when_empty: assert property (
      @(posedge clk) disable iff (reset) !(i_pop && i_empty)
   ) else $error("pop issued while the fifo is empty");

   ////////////////////////////////////////
   // wishbone side
   ////////////////////////////////////////

   // ack exactly one clock after strobe
   a_ack_after_stb: assert property (
      @(posedge clk) disable iff (reset) i_stb |=> i_ack
   ) else $error("no ack one cycle after strobe");

endmodule

bind sample_fifo audio_peripheral_assertions u_fifo_checks (
   .clk     (clk),
   .reset   (reset),
   .i_push  (push_bus.push),
   .i_full  (full),
   .i_pop   (i_pop),
   .i_empty (o_empty),
   .i_stb   (1'b0),
   .i_ack   (1'b0)
);

bind wishbone_bus_logic audio_peripheral_assertions u_bus_checks (
   .clk     (clk),
   .reset   (reset),
   .i_push  (1'b0),
   .i_full  (1'b0),
   .i_pop   (1'b0),
   .i_empty (1'b0),
   .i_stb   (i_wb_stb),
   .i_ack   (o_wb_ack)
);

`default_nettype wire

// ==== hdl/audio_peripheral_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module audio_peripheral_top #(
   parameter int FIFO_DEPTH  = 4,
   parameter int BCLK_DIV    = 2,
   parameter int INIT_CYCLES = 64
) (
   input  wire logic        clk,
   input  wire logic        reset,
   // wishbone slave
   input  wire logic        i_wb_stb,
   input  wire logic        i_wb_we,
   input  wire logic [31:0] i_wb_addr,
   input  wire logic [31:0] i_wb_data,
   input  wire logic [3:0]  i_wb_sel,
   output logic             o_wb_ack,
   output logic [31:0]      o_wb_data,
   // board i/o
   input  wire logic [7:0]  i_dip,
   input  wire logic [4:0]  i_buttons,
   output logic [7:0]       o_led,
   // i2s out
   output logic             o_i2s_bclk,
   output logic             o_i2s_lrclk,
   output logic             o_i2s_sdata
);

   audio_pkg::stereo_sample_t fifo_head;
   logic                      fifo_empty;
   logic                      fifo_pop;
   logic                      init_done;

   // register block to fifo
   sample_push_if push_bus ();

   ////////////////////////////////////////
   // blocks
   ////////////////////////////////////////

   wishbone_bus_logic u_bus (
      .clk         (clk),
      .reset       (reset),
      .i_wb_stb    (i_wb_stb),
      .i_wb_we     (i_wb_we),
      .i_wb_addr   (i_wb_addr),
      .i_wb_data   (i_wb_data),
      .i_wb_sel    (i_wb_sel),
      .o_wb_ack    (o_wb_ack),
      .o_wb_data   (o_wb_data),
      .i_dip       (i_dip),
      .i_buttons   (i_buttons),
      .o_led       (o_led),
      .i_init_done (init_done),
      .push_bus    (push_bus.producer)
   );

   sample_fifo #(
      .FIFO_DEPTH (FIFO_DEPTH)
   ) u_fifo (
      .clk      (clk),
      .reset    (reset),
      .push_bus (push_bus.consumer),
      .i_pop    (fifo_pop),
      .o_head   (fifo_head),
      .o_empty  (fifo_empty)
   );

   // drains the fifo one frame at a time
   i2s_transmitter #(
      .BCLK_DIV    (BCLK_DIV),
      .INIT_CYCLES (INIT_CYCLES)
   ) u_i2s (
      .clk         (clk),
      .reset       (reset),
      .i_head      (fifo_head),
      .i_empty     (fifo_empty),
      .o_pop       (fifo_pop),
      .o_init_done (init_done),
      .o_i2s_bclk  (o_i2s_bclk),
      .o_i2s_lrclk (o_i2s_lrclk),
      .o_i2s_sdata (o_i2s_sdata)
   );

endmodule

`default_nettype wire

// ==== hdl/i2s_transmitter.sv ====
`timescale 1ns/1ns
`default_nettype none

module i2s_transmitter #(
   parameter int BCLK_DIV    = 2,
   parameter int INIT_CYCLES = 64
) (
   input  wire logic                       clk,
   input  wire logic                       reset,
   input  wire audio_pkg::stereo_sample_t  i_head,
   input  wire logic                       i_empty,
   output logic                            o_pop,
   output logic                            o_init_done,
   output logic                            o_i2s_bclk,
   output logic                            o_i2s_lrclk,
   output logic                            o_i2s_sdata
);

   localparam int DIV_W  = (BCLK_DIV > 1) ? $clog2(BCLK_DIV) : 1;
   localparam int INIT_W = $clog2(INIT_CYCLES + 1);

   logic [DIV_W-1:0]          div_cnt;
   logic                      half_tick;
   logic                      fall_tick;
   logic [5:0]                slot;
   logic [5:0]                slot_next;
   logic                      next_bit;
   logic [INIT_W-1:0]         init_cnt;
   // frame latched at slot 0
   audio_pkg::stereo_sample_t frame;

   ////////////////////////////////////////
   // bit clock divider
   ////////////////////////////////////////

   assign half_tick = (div_cnt == DIV_W'(BCLK_DIV - 1));
   // bclk about to go low
   assign fall_tick = half_tick && o_i2s_bclk;
   assign slot_next = slot + 1'b1;

   always_ff @(posedge clk) begin
      if (reset) begin
         div_cnt    <= '0;
         o_i2s_bclk <= 1'b0;
      end else begin
         div_cnt <= half_tick ? '0 : div_cnt + 1'b1;
         if (half_tick)
            o_i2s_bclk <= ~o_i2s_bclk;
      end
   end

   ////////////////////////////////////////
   // frame serializer
   ////////////////////////////////////////

   // msb one slot after the ws edge, then 24 bits, then zeros
   always_comb begin
      int idx;
      idx      = int'(slot_next[4:0]);
      next_bit = 1'b0;
      if (idx >= 1 && idx <= audio_pkg::SAMPLE_W)
         next_bit = slot_next[5] ? frame.right[audio_pkg::SAMPLE_W - idx]
                                 : frame.left[audio_pkg::SAMPLE_W - idx];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         // first falling edge starts slot 0
         slot        <= '1;
         o_i2s_lrclk <= 1'b0;
         o_i2s_sdata <= 1'b0;
         o_pop       <= 1'b0;
         frame       <= '0;
      end else begin
         o_pop <= 1'b0;
         if (fall_tick) begin
            slot        <= slot_next;
            o_i2s_lrclk <= slot_next[5];
            o_i2s_sdata <= next_bit;
            if (slot_next == 6'd0) begin
               // take the head word, or send silence
               if (o_init_done && !i_empty) begin
                  frame <= i_head;
                  o_pop <= 1'b1;
               end else begin
                  frame <= '0;
               end
            end
         end
      end
   end

   ////////////////////////////////////////
   // power-up init timer
   ////////////////////////////////////////

   // stands in for codec configuration
   always_ff @(posedge clk) begin
      if (reset) begin
         init_cnt    <= INIT_W'(INIT_CYCLES);
         o_init_done <= 1'b0;
      end else if (init_cnt != '0) begin
         init_cnt    <= init_cnt - 1'b1;
         o_init_done <= (init_cnt == INIT_W'(1));
      end
   end

endmodule

`default_nettype wire

// ==== hdl/sample_fifo.sv ====
`timescale 1ns/1ns
`default_nettype none

module sample_fifo #(
   parameter int FIFO_DEPTH = 4
) (
   input  wire logic                  clk,
   input  wire logic                  reset,
   sample_push_if.consumer            push_bus,
   input  wire logic                  i_pop,
   output audio_pkg::stereo_sample_t  o_head,
   output logic                       o_empty
);

   localparam int ADDR_W = $clog2(FIFO_DEPTH);

   // entry storage
   audio_pkg::stereo_sample_t mem [FIFO_DEPTH];

   // one extra bit to tell full from empty
   logic [ADDR_W:0] wr_ptr;
   logic [ADDR_W:0] rd_ptr;
   logic            full;

   ////////////////////////////////////////
   // pointers
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         wr_ptr <= '0;
         rd_ptr <= '0;
      end else begin
         if (push_bus.push)
            wr_ptr <= wr_ptr + 1'b1;
         if (i_pop)
            rd_ptr <= rd_ptr + 1'b1;
      end
   end

   // write side
   always_ff @(posedge clk) begin
      if (push_bus.push) begin
         mem[wr_ptr[ADDR_W-1:0]].left  <= push_bus.left;
         mem[wr_ptr[ADDR_W-1:0]].right <= push_bus.right;
      end
   end

   ////////////////////////////////////////
   // flags and head
   ////////////////////////////////////////

   // full when the index matches and the wrap bits differ
   assign full = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                 (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

   assign o_empty = (wr_ptr == rd_ptr);

   assign push_bus.full = full;

   // head entry shows until it is popped
   assign o_head = mem[rd_ptr[ADDR_W-1:0]];

endmodule

`default_nettype wire

// ==== hdl/wishbone_bus_logic.sv ====
`timescale 1ns/1ns
`default_nettype none

module wishbone_bus_logic (
   input  wire logic        clk,
   input  wire logic        reset,
   // classic single-cycle wishbone slave
   input  wire logic        i_wb_stb,
   input  wire logic        i_wb_we,
   input  wire logic [31:0] i_wb_addr,
   input  wire logic [31:0] i_wb_data,
   input  wire logic [3:0]  i_wb_sel,
   output logic             o_wb_ack,
   output logic [31:0]      o_wb_data,
   // board i/o
   input  wire logic [7:0]  i_dip,
   input  wire logic [4:0]  i_buttons,
   output logic [7:0]       o_led,
   // level from the transmitter init timer
   input  wire logic        i_init_done,
   sample_push_if.producer  push_bus
);

   localparam int SAMPLE_BYTES = audio_pkg::SAMPLE_W / 8;

   logic                           wr_en;
   logic                           rd_en;
   logic [31:0]                    rd_word;
   logic [audio_pkg::SAMPLE_W-1:0] left_q;
   logic [audio_pkg::SAMPLE_W-1:0] right_q;
   // stereo word written, not yet in the fifo
   logic                           pending;
   logic                           push;

   assign wr_en = i_wb_stb && i_wb_we;
   assign rd_en = i_wb_stb && !i_wb_we;

   ////////////////////////////////////////
   // read path
   ////////////////////////////////////////

   always_comb begin
      rd_word = '0;
      case (i_wb_addr)
         audio_pkg::ADDR_DIP:     rd_word[7:0] = i_dip;
         audio_pkg::ADDR_LED:     rd_word[7:0] = o_led;
         audio_pkg::ADDR_BUTTONS: rd_word[4:0] = i_buttons;
         audio_pkg::ADDR_STATUS: begin
            rd_word[audio_pkg::STAT_FULL_BIT] = push_bus.full;
            rd_word[audio_pkg::STAT_INIT_BIT] = i_init_done;
            rd_word[audio_pkg::STAT_PEND_BIT] = pending;
         end
         // left/right are write-only, rest unmapped
         default:                 rd_word = '0;
      endcase
   end

   // data lines up with ack, zero on write cycles
   always_ff @(posedge clk) begin
      o_wb_data <= rd_en ? rd_word : 32'h0;
   end

   // ack one clock after every strobe, bus never stalls
   always_ff @(posedge clk) begin
      if (reset) begin
         o_wb_ack <= 1'b0;
      end else begin
         o_wb_ack <= i_wb_stb;
      end
   end

   ////////////////////////////////////////
   // write path
   ////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (reset) begin
         o_led <= 8'h00;
      end else if (wr_en && (i_wb_addr == audio_pkg::ADDR_LED) && i_wb_sel[0]) begin
         o_led <= i_wb_data[7:0];
      end
   end

   // sample registers, byte lanes 0..2 only
   always_ff @(posedge clk) begin
      for (int b = 0; b < SAMPLE_BYTES; b++) begin
         if (wr_en && i_wb_sel[b]) begin
            if (i_wb_addr == audio_pkg::ADDR_LEFT)
               left_q[8*b +: 8] <= i_wb_data[8*b +: 8];
            if (i_wb_addr == audio_pkg::ADDR_RIGHT)
               right_q[8*b +: 8] <= i_wb_data[8*b +: 8];
         end
      end
   end

   ////////////////////////////////////////
   // pending word and fifo push
   ////////////////////////////////////////

   // push as soon as the fifo has room
   assign push = pending && !push_bus.full;

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
      end else if (wr_en && (i_wb_addr == audio_pkg::ADDR_RIGHT) && (|i_wb_sel)) begin
         // a new right write wins over a push in the same cycle
         pending <= 1'b1;
      end else if (push) begin
         pending <= 1'b0;
      end
   end

   // registers hold until the push edge, so the fifo takes the old word
   assign push_bus.left  = left_q;
   assign push_bus.right = right_q;
   assign push_bus.push  = push;

endmodule

`default_nettype wire

// ==== hdl/sample_push_if.sv ====
`timescale 1ns/1ns
`default_nettype none

// stereo word handoff, register block into fifo write side
interface sample_push_if;

   logic [audio_pkg::SAMPLE_W-1:0] left;
   logic [audio_pkg::SAMPLE_W-1:0] right;
   // one-cycle strobe, only while full is low
   logic                           push;
   logic                           full;

   modport producer (
      output left, right, push,
      input  full
   );

   modport consumer (
      input  left, right, push,
      output full
   );

endinterface

`default_nettype wire

// ==== hdl/audio_pkg.sv ====
`default_nettype none

package audio_pkg;

   ////////////////////////////////////////
   // sample format
   ////////////////////////////////////////

   // one channel, twos complement
   localparam int SAMPLE_W = 24;

   // one stereo word as it sits in the fifo
   typedef struct packed {
      logic [SAMPLE_W-1:0] left;
      logic [SAMPLE_W-1:0] right;
   } stereo_sample_t;

   ////////////////////////////////////////
   // wishbone register map
   ////////////////////////////////////////

   localparam logic [31:0] ADDR_DIP     = 32'h9000_0000;
   localparam logic [31:0] ADDR_LED     = 32'h9000_0004;
   localparam logic [31:0] ADDR_BUTTONS = 32'h9000_0008;
   localparam logic [31:0] ADDR_STATUS  = 32'h9000_000C;
   localparam logic [31:0] ADDR_LEFT    = 32'h9000_0010;
   localparam logic [31:0] ADDR_RIGHT   = 32'h9000_0014;

   // status word bit positions
   localparam int STAT_FULL_BIT = 0;
   localparam int STAT_INIT_BIT = 1;
   localparam int STAT_PEND_BIT = 2;

endpackage

`default_nettype wire
